// File: compile.f
+incdir+design
design/ita_ctrl_pkg.sv
design/ita_data_pkg.sv
design/ita_issue_gate.sv
design/ita_tile_sequencer.sv
design/ita_pad_mask.sv
design/ita_lane_pad_reg.sv
design/ita_controller_top.sv
dv/tb_clk_gen.sv
dv/ita_controller_assertions.sv
dv/tb_ita_controller.sv

// File: design/ita_consts.svh
/* sizing constants for the tile controller
   include in every file that needs a lane count, tile size or width */

`ifndef ITA_CONSTS_SVH
`define ITA_CONSTS_SVH

`define ITA_N 4
`define ITA_M 8
`define ITA_BEATS ((`ITA_M * `ITA_M) / `ITA_N)
`define ITA_FIFO_DEPTH 4

`define ITA_DIM_W 10
`define ITA_CNT_W 8
`define ITA_BIAS_W 24

`endif

// File: design/ita_controller_top.sv
/* tile sequencing controller for linear and feedforward layers
   issue gate -> sequencer -> pad mask -> bias and requant pad registers */

`timescale 1ns/1ps
`default_nettype none

`include "ita_consts.svh"

module ita_controller_top (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     start_i,
  input  ita_ctrl_pkg::layer_e      layer_i,
  input  ita_ctrl_pkg::dim_t        seq_length_i,
  input  ita_ctrl_pkg::dim_t        proj_space_i,
  input  ita_ctrl_pkg::dim_t        embed_size_i,
  input  ita_ctrl_pkg::dim_t        ff_size_i,
  input  ita_ctrl_pkg::counter_t    tile_s_i,
  input  ita_ctrl_pkg::counter_t    tile_p_i,
  input  ita_ctrl_pkg::counter_t    tile_e_i,
  input  ita_ctrl_pkg::counter_t    tile_f_i,
  input  logic                     inp_valid_i,
  output logic                     inp_ready_o,
  input  logic                     weight_valid_i,
  output logic                     weight_ready_o,
  input  logic                     bias_valid_i,
  output logic                     bias_ready_o,
  input  logic                     oup_valid_i,
  input  logic                     oup_ready_i,
  input  ita_data_pkg::bias_vec_t   bias_i,
  input  logic                     requant_add_i, // broadcast to all lanes
  output logic                     calc_en_o,
  output ita_ctrl_pkg::step_e       step_o,
  output logic                     first_inner_tile_o,
  output logic                     last_inner_tile_o,
  output ita_ctrl_pkg::counter_t    tile_x_o,
  output ita_ctrl_pkg::counter_t    tile_y_o,
  output ita_ctrl_pkg::counter_t    inner_tile_o,
  output ita_data_pkg::bias_vec_t   bias_pad_o,
  output ita_data_pkg::lane_mask_t  requant_add_o,
  output logic                     pad_valid_o,
  output logic                     busy_o
);

  logic fire;
  logic active;
  ita_ctrl_pkg::counter_t beat;
  ita_data_pkg::lane_mask_t keep;

  assign calc_en_o = fire;
  assign busy_o    = active;

  ita_issue_gate ita_issue_gate_inst (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .active_i       (active),
    .last_inner_i   (last_inner_tile_o),
    .inp_valid_i    (inp_valid_i),
    .weight_valid_i (weight_valid_i),
    .bias_valid_i   (bias_valid_i),
    .oup_valid_i    (oup_valid_i),
    .oup_ready_i    (oup_ready_i),
    .inp_ready_o    (inp_ready_o),
    .weight_ready_o (weight_ready_o),
    .bias_ready_o   (bias_ready_o),
    .fire_o         (fire)
  );

  ita_tile_sequencer ita_tile_sequencer_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .start_i       (start_i),
    .layer_i       (layer_i),
    .fire_i        (fire),
    .tile_s_i      (tile_s_i),
    .tile_p_i      (tile_p_i),
    .tile_e_i      (tile_e_i),
    .tile_f_i      (tile_f_i),
    .step_o        (step_o),
    .active_o      (active),
    .last_inner_o  (last_inner_tile_o),
    .first_inner_o (first_inner_tile_o),
    .beat_o        (beat),
    .tile_x_o      (tile_x_o),
    .tile_y_o      (tile_y_o),
    .inner_tile_o  (inner_tile_o)
  );

  ita_pad_mask ita_pad_mask_inst (
    .step_i       (step_o),
    .beat_i       (beat),
    .tile_x_i     (tile_x_o),
    .tile_y_i     (tile_y_o),
    .seq_length_i (seq_length_i),
    .proj_space_i (proj_space_i),
    .embed_size_i (embed_size_i),
    .ff_size_i    (ff_size_i),
    .keep_o       (keep)
  );

  ita_lane_pad_reg #(
    .lane_t (ita_data_pkg::bias_lane_t)
  ) bias_pad_inst (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .load_i  (fire),
    .keep_i  (keep),
    .data_i  (bias_i),
    .data_o  (bias_pad_o),
    .valid_o (pad_valid_o)
  );

  // same strobe timing as the bias copy, its valid is not needed
  ita_lane_pad_reg #(
    .lane_t (logic)
  ) requant_pad_inst (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .load_i  (fire),
    .keep_i  (keep),
    .data_i  ({`ITA_N{requant_add_i}}),
    .data_o  (requant_add_o),
    .valid_o ()
  );

endmodule

`default_nettype wire

// File: design/ita_ctrl_pkg.sv
/* sequencing types: step state, layer request, counters, dimensions
   referenced by scoped name from the controller modules */

`default_nettype none

`include "ita_consts.svh"

package ita_ctrl_pkg;

  typedef enum logic [1:0] {
    Idle   = 2'd0,
    MatMul = 2'd1, // linear layer
    F1     = 2'd2,
    F2     = 2'd3
  } step_e;

  typedef enum logic {
    Linear      = 1'b0,
    Feedforward = 1'b1
  } layer_e;

  typedef logic [`ITA_CNT_W-1:0] counter_t;
  typedef logic [`ITA_DIM_W-1:0] dim_t;

endpackage

`default_nettype wire

// File: design/ita_data_pkg.sv
/* datapath lane types for the bias and requant pad stage
   referenced by scoped name, never imported */

`default_nettype none

`include "ita_consts.svh"

package ita_data_pkg;

  typedef logic signed [`ITA_BIAS_W-1:0] bias_lane_t;

  typedef bias_lane_t [`ITA_N-1:0] bias_vec_t;

  // one keep bit per lane
  typedef logic [`ITA_N-1:0] lane_mask_t;

endpackage

`default_nettype wire

// File: design/ita_issue_gate.sv
/* operand handshake plus output credit counter
   fire_o marks a beat accepted on all three operand streams */

`timescale 1ns/1ps
`default_nettype none

`include "ita_consts.svh"

module ita_issue_gate (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic active_i,
  input  logic last_inner_i,
  input  logic inp_valid_i,
  input  logic weight_valid_i,
  input  logic bias_valid_i,
  input  logic oup_valid_i,
  input  logic oup_ready_i,
  output logic inp_ready_o,
  output logic weight_ready_o,
  output logic bias_ready_o,
  output logic fire_o
);

  localparam int CREDIT_W = $clog2(`ITA_FIFO_DEPTH + 1);
  localparam logic [CREDIT_W-1:0] DEPTH = CREDIT_W'(`ITA_FIFO_DEPTH);

  logic [CREDIT_W-1:0] credit_q;
  logic stall;
  logic push;
  logic pop;

  assign stall = !active_i || (credit_q >= DEPTH); // output fifo full

  // cross-coupled readies, as in the accelerator datapath
  assign inp_ready_o    = stall ? 1'b0 : weight_valid_i;
  assign weight_ready_o = stall ? 1'b0 : inp_valid_i;
  assign bias_ready_o   = stall ? 1'b0 : weight_valid_i;

  assign fire_o = !stall && inp_valid_i && weight_valid_i && bias_valid_i;

  assign push = fire_o && last_inner_i; // result headed for the output fifo
  assign pop  = oup_valid_i && oup_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      credit_q <= '0;
    end else if (push && !pop) begin
      credit_q <= credit_q + 1'b1;
    end else if (pop && !push) begin
      credit_q <= credit_q - 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: design/ita_lane_pad_reg.sv
/* registered pad stage for one N-lane payload
   masked lanes load as zero; valid_o pulses one cycle after load_i */

`timescale 1ns/1ps
`default_nettype none

`include "ita_consts.svh"

module ita_lane_pad_reg #(
  parameter type lane_t = logic
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     load_i,
  input  ita_data_pkg::lane_mask_t keep_i,
  input  lane_t [`ITA_N-1:0]       data_i,
  output lane_t [`ITA_N-1:0]       data_o,
  output logic                     valid_o
);

  lane_t [`ITA_N-1:0] data_q;
  logic valid_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= load_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load_i) begin
      for (int i = 0; i < `ITA_N; i++) begin
        data_q[i] <= keep_i[i] ? data_i[i] : lane_t'(0);
      end
    end
  end

  assign data_o  = data_q;
  assign valid_o = valid_q;

endmodule

`default_nettype wire

// File: design/ita_pad_mask.sv
/* edge lane mask for the current beat
   rows past seq_length and columns past the step's output width are dropped */

`timescale 1ns/1ps
`default_nettype none

`include "ita_consts.svh"

module ita_pad_mask (
  input  ita_ctrl_pkg::step_e      step_i,
  input  ita_ctrl_pkg::counter_t   beat_i,
  input  ita_ctrl_pkg::counter_t   tile_x_i,
  input  ita_ctrl_pkg::counter_t   tile_y_i,
  input  ita_ctrl_pkg::dim_t       seq_length_i,
  input  ita_ctrl_pkg::dim_t       proj_space_i,
  input  ita_ctrl_pkg::dim_t       embed_size_i,
  input  ita_ctrl_pkg::dim_t       ff_size_i,
  output ita_data_pkg::lane_mask_t keep_o
);

  // room for tile index times M plus the in-tile offset
  localparam int POS_W = `ITA_CNT_W + $clog2(`ITA_M) + 1;

  logic [POS_W-1:0] row, col_base;
  ita_ctrl_pkg::dim_t col_dim;

  always_comb begin
    case (step_i)
      ita_ctrl_pkg::F1: col_dim = ff_size_i;
      ita_ctrl_pkg::F2: col_dim = embed_size_i;
      default:          col_dim = proj_space_i; // MatMul
    endcase
  end

  assign row      = POS_W'(beat_i % `ITA_M) + POS_W'(tile_y_i) * POS_W'(`ITA_M);
  assign col_base = POS_W'((beat_i / `ITA_M) * `ITA_N) + POS_W'(tile_x_i) * POS_W'(`ITA_M);

  always_comb begin
    keep_o = '0;
    if (row < POS_W'(seq_length_i)) begin
      for (int i = 0; i < `ITA_N; i++) begin
        keep_o[i] = (col_base + POS_W'(i)) < POS_W'(col_dim);
      end
    end
  end

endmodule

`default_nettype wire

// File: design/ita_tile_sequencer.sv
/* step FSM with nested beat, inner tile and outer tile counters
   advances one beat per fire; linear runs MatMul, feedforward runs F1 then F2 */

`timescale 1ns/1ps
`default_nettype none

`include "ita_consts.svh"

module ita_tile_sequencer (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  start_i,
  input  ita_ctrl_pkg::layer_e   layer_i,
  input  logic                  fire_i,
  input  ita_ctrl_pkg::counter_t tile_s_i,
  input  ita_ctrl_pkg::counter_t tile_p_i,
  input  ita_ctrl_pkg::counter_t tile_e_i,
  input  ita_ctrl_pkg::counter_t tile_f_i,
  output ita_ctrl_pkg::step_e    step_o,
  output logic                  active_o,
  output logic                  last_inner_o,
  output logic                  first_inner_o,
  output ita_ctrl_pkg::counter_t beat_o,
  output ita_ctrl_pkg::counter_t tile_x_o,
  output ita_ctrl_pkg::counter_t tile_y_o,
  output ita_ctrl_pkg::counter_t inner_tile_o
);

  localparam ita_ctrl_pkg::counter_t LAST_BEAT = ita_ctrl_pkg::counter_t'(`ITA_BEATS - 1);

  ita_ctrl_pkg::step_e    step_d, step_q;
  ita_ctrl_pkg::counter_t beat_d, beat_q;
  ita_ctrl_pkg::counter_t inner_d, inner_q;
  ita_ctrl_pkg::counter_t x_d, x_q;
  ita_ctrl_pkg::counter_t y_d, y_q;
  ita_ctrl_pkg::counter_t inner_lim, x_lim;
  logic last_beat, last_inner, last_x, last_y;

  // per-step loop bounds
  always_comb begin
    inner_lim = tile_e_i;
    x_lim     = tile_p_i;
    case (step_q)
      ita_ctrl_pkg::F1: x_lim = tile_f_i;
      ita_ctrl_pkg::F2: begin
        inner_lim = tile_f_i;
        x_lim     = tile_e_i;
      end
      default: ;
    endcase
  end

  assign last_beat  = (beat_q == LAST_BEAT);
  assign last_inner = (inner_q == inner_lim - 1'b1);
  assign last_x     = (x_q == x_lim - 1'b1);
  assign last_y     = (y_q == tile_s_i - 1'b1);

  always_comb begin
    step_d  = step_q;
    beat_d  = beat_q;
    inner_d = inner_q;
    x_d     = x_q;
    y_d     = y_q;
    if (step_q == ita_ctrl_pkg::Idle) begin
      beat_d  = '0;
      inner_d = '0;
      x_d     = '0;
      y_d     = '0;
      if (start_i) begin
        step_d = (layer_i == ita_ctrl_pkg::Feedforward) ? ita_ctrl_pkg::F1 : ita_ctrl_pkg::MatMul;
      end
    end else if (fire_i) begin
      beat_d = beat_q + 1'b1;
      if (last_beat) begin // end of tile
        beat_d  = '0;
        inner_d = inner_q + 1'b1;
        if (last_inner) begin
          inner_d = '0;
          x_d     = x_q + 1'b1;
          if (last_x) begin
            x_d = '0;
            y_d = y_q + 1'b1;
            if (last_y) begin // end of step
              y_d    = '0;
              step_d = (step_q == ita_ctrl_pkg::F1) ? ita_ctrl_pkg::F2 : ita_ctrl_pkg::Idle;
            end
          end
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      step_q  <= ita_ctrl_pkg::Idle;
      beat_q  <= '0;
      inner_q <= '0;
      x_q     <= '0;
      y_q     <= '0;
    end else begin
      step_q  <= step_d;
      beat_q  <= beat_d;
      inner_q <= inner_d;
      x_q     <= x_d;
      y_q     <= y_d;
    end
  end

  assign step_o        = step_q;
  assign active_o      = (step_q != ita_ctrl_pkg::Idle);
  assign last_inner_o  = active_o && last_inner;
  assign first_inner_o = (inner_q == '0);
  assign beat_o        = beat_q;
  assign tile_x_o      = x_q;
  assign tile_y_o      = y_q;
  assign inner_tile_o  = inner_q;

endmodule

`default_nettype wire

// File: dv/ita_controller_assertions.sv
/* concurrent checks on the issue gate, bound into every instance of it
   covers the credit stall, the fire condition and the reset state */

`timescale 1ns/1ps
`default_nettype none

`include "ita_consts.svh"

module ita_controller_assertions (
  input logic                                   clk_i,
  input logic                                   rst_ni,
  input logic [$clog2(`ITA_FIFO_DEPTH + 1)-1:0] credit_i,
  input logic                                   inp_valid_i,
  input logic                                   weight_valid_i,
  input logic                                   bias_valid_i,
  input logic                                   inp_ready_i,
  input logic                                   weight_ready_i,
  input logic                                   bias_ready_i,
  input logic                                   fire_i
);

  localparam int DEPTH = `ITA_FIFO_DEPTH;

  full_blocks_issue: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (int'(credit_i) >= DEPTH) |-> !(inp_ready_i || weight_ready_i || bias_ready_i))
    else $error("a ready is high while all output credits are in use");

  fire_needs_valids: assert property (@(posedge clk_i) disable iff (!rst_ni)
    fire_i |-> (inp_valid_i && weight_valid_i && bias_valid_i))
    else $error("fire without all three operand valids");

  credit_bounded: assert property (@(posedge clk_i) disable iff (!rst_ni)
    int'(credit_i) <= DEPTH)
    else $error("credit count ran past the fifo depth");

  // held in reset: empty credits, no handshake
  reset_state: assert property (@(posedge clk_i)
    !rst_ni |-> (credit_i == '0) && !fire_i && !inp_ready_i && !weight_ready_i && !bias_ready_i)
    else $error("issue gate not idle during reset");

endmodule

bind ita_issue_gate ita_controller_assertions ita_controller_assertions_inst (
  .clk_i          (clk_i),
  .rst_ni         (rst_ni),
  .credit_i       (credit_q),
  .inp_valid_i    (inp_valid_i),
  .weight_valid_i (weight_valid_i),
  .bias_valid_i   (bias_valid_i),
  .inp_ready_i    (inp_ready_o),
  .weight_ready_i (weight_ready_o),
  .bias_ready_i   (bias_ready_o),
  .fire_i         (fire_o)
);

`default_nettype wire

// File: dv/tb_clk_gen.sv
/* free-running 10 ns clock and the power-on reset pulse for the testbench */

`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  initial begin
    rst_no = 1'b0;
    repeat (8) @(posedge clk_o);
    #1 rst_no = 1'b1; // released just off the edge
  end

endmodule

`default_nettype wire

// File: dv/tb_ita_controller.sv
/* applies a table of linear and feedforward jobs to the tile controller
   and checks handshake, tile order, back-pressure and edge padding cycle by cycle */

`timescale 1ns/1ps
`default_nettype none

`include "ita_consts.svh"

module tb_ita_controller;

  typedef struct {
    ita_ctrl_pkg::layer_e layer;
    int seq, proj, embed, ff; // matrix dimensions
    int ts, tp, te, tf;       // tile counts
    bit bp;                   // hold oup_ready low until issue stalls
    bit rand_valid;
  } job_t;

  localparam int NUM_JOBS    = 3;
  localparam int HOLD_CYCLES = 12;

  logic clk;
  logic rst_n;
  logic start;
  ita_ctrl_pkg::layer_e layer;
  ita_ctrl_pkg::dim_t seq_length, proj_space, embed_size, ff_size;
  ita_ctrl_pkg::counter_t tile_s, tile_p, tile_e, tile_f;
  logic inp_valid, inp_ready, weight_valid, weight_ready, bias_valid, bias_ready;
  logic oup_valid, oup_ready, requant_add;
  ita_data_pkg::bias_vec_t bias, bias_pad, exp_bias;
  ita_data_pkg::lane_mask_t requant_pad, exp_req;
  logic calc_en, first_inner, last_inner, pad_valid, busy;
  ita_ctrl_pkg::step_e step;
  ita_ctrl_pkg::counter_t tile_x, tile_y, inner_tile;

  // reference model state
  job_t jobs [NUM_JOBS];
  ita_ctrl_pkg::step_e step_m = ita_ctrl_pkg::Idle;
  int idx = 0; // beats issued in the current step
  int credit_m = 0;
  int cur_job = 0;
  int fires [4];
  int hold_cnt;
  int errors = 0;
  logic pad_pending = 1'b0;
  logic bp_hold = 1'b0;
  logic saw_full;
  integer seed;

  tb_clk_gen clk_gen_inst (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  ita_controller_top ita_controller_top_inst (
    .clk_i (clk), .rst_ni (rst_n), .start_i (start), .layer_i (layer),
    .seq_length_i (seq_length), .proj_space_i (proj_space),
    .embed_size_i (embed_size), .ff_size_i (ff_size),
    .tile_s_i (tile_s), .tile_p_i (tile_p), .tile_e_i (tile_e), .tile_f_i (tile_f),
    .inp_valid_i (inp_valid), .inp_ready_o (inp_ready),
    .weight_valid_i (weight_valid), .weight_ready_o (weight_ready),
    .bias_valid_i (bias_valid), .bias_ready_o (bias_ready),
    .oup_valid_i (oup_valid), .oup_ready_i (oup_ready),
    .bias_i (bias), .requant_add_i (requant_add), .calc_en_o (calc_en), .step_o (step),
    .first_inner_tile_o (first_inner), .last_inner_tile_o (last_inner),
    .tile_x_o (tile_x), .tile_y_o (tile_y), .inner_tile_o (inner_tile),
    .bias_pad_o (bias_pad), .requant_add_o (requant_pad),
    .pad_valid_o (pad_valid), .busy_o (busy)
  );

  task automatic stop_on_error(input string why);
    errors++;
    $display("%s", why);
    $display("Test failures found");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [127:0] got,
                             input logic [127:0] exp);
    assert (got === exp) else
      stop_on_error($sformatf("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, exp));
  endtask

  // sample at the falling edge and drive just after the rising edge
  task automatic advance_cycle();
    logic stall, fire, push, pop;
    int in_lim, x_lim, col_dim, beat, t, inner, x, y, row;
    ita_data_pkg::lane_mask_t keep;
    @(negedge clk);
    check_value("pad_valid_o", 128'(pad_valid), 128'(pad_pending));
    if (pad_pending) begin
      check_value("bias_pad_o", 128'(bias_pad), 128'(exp_bias));
      check_value("requant_add_o", 128'(requant_pad), 128'(exp_req));
    end
    check_value("step_o", 128'(step), 128'(step_m));
    check_value("busy_o", 128'(busy), 128'(step_m != ita_ctrl_pkg::Idle));
    stall = (step_m == ita_ctrl_pkg::Idle) || (credit_m >= `ITA_FIFO_DEPTH);
    check_value("inp_ready_o", 128'(inp_ready), 128'(!stall && weight_valid));
    check_value("weight_ready_o", 128'(weight_ready), 128'(!stall && inp_valid));
    check_value("bias_ready_o", 128'(bias_ready), 128'(!stall && weight_valid));
    fire = !stall && inp_valid && weight_valid && bias_valid;
    check_value("calc_en_o", 128'(calc_en), 128'(fire));
    if (calc_en) begin
      fires[int'(step)]++; // counted from the DUT outputs
    end
    push = 1'b0;
    if (fire) begin
      in_lim  = (step_m == ita_ctrl_pkg::F2) ? jobs[cur_job].tf : jobs[cur_job].te;
      x_lim   = (step_m == ita_ctrl_pkg::F1) ? jobs[cur_job].tf :
                (step_m == ita_ctrl_pkg::F2) ? jobs[cur_job].te : jobs[cur_job].tp;
      col_dim = (step_m == ita_ctrl_pkg::F1) ? jobs[cur_job].ff :
                (step_m == ita_ctrl_pkg::F2) ? jobs[cur_job].embed : jobs[cur_job].proj;
      beat  = idx % `ITA_BEATS;
      t     = idx / `ITA_BEATS; // tiles done in this step
      inner = t % in_lim;
      x     = (t / in_lim) % x_lim;
      y     = (t / in_lim) / x_lim;
      check_value("inner_tile_o", 128'(inner_tile), 128'(inner));
      check_value("tile_x_o", 128'(tile_x), 128'(x));
      check_value("tile_y_o", 128'(tile_y), 128'(y));
      check_value("first_inner_tile_o", 128'(first_inner), 128'(inner == 0));
      check_value("last_inner_tile_o", 128'(last_inner), 128'(inner == in_lim - 1));
      push = (inner == in_lim - 1);
      row  = beat % `ITA_M + y * `ITA_M;
      for (int i = 0; i < `ITA_N; i++) begin
        keep[i] = (row < jobs[cur_job].seq) &&
                  ((beat / `ITA_M) * `ITA_N + x * `ITA_M + i < col_dim);
        exp_bias[i] = keep[i] ? bias[i] : '0;
        exp_req[i]  = keep[i] && requant_add;
      end
      idx++;
      if (idx == jobs[cur_job].ts * x_lim * in_lim * `ITA_BEATS) begin
        idx    = 0;
        step_m = (step_m == ita_ctrl_pkg::F1) ? ita_ctrl_pkg::F2 : ita_ctrl_pkg::Idle;
      end
    end else if (step_m == ita_ctrl_pkg::Idle && start) begin
      step_m = (layer == ita_ctrl_pkg::Feedforward) ? ita_ctrl_pkg::F1 : ita_ctrl_pkg::MatMul;
    end
    pad_pending = fire;
    pop = oup_valid && oup_ready;
    if (push && !pop) begin
      credit_m++;
    end else if (pop && !push) begin
      credit_m--;
    end
    if (credit_m >= `ITA_FIFO_DEPTH) saw_full = 1'b1;
    if (bp_hold && stall && step_m != ita_ctrl_pkg::Idle) begin
      hold_cnt++;
      if (hold_cnt >= HOLD_CYCLES) bp_hold = 1'b0; // let the fifo drain
    end
    @(posedge clk);
    #1;
    start = 1'b0;
    for (int i = 0; i < `ITA_N; i++) bias[i] = ita_data_pkg::bias_lane_t'($random(seed));
    requant_add = 1'($random(seed));
    if (jobs[cur_job].rand_valid) begin
      inp_valid    = ($random(seed) & 3) != 0;
      weight_valid = ($random(seed) & 3) != 0;
      bias_valid   = ($random(seed) & 3) != 0;
    end else begin
      inp_valid    = 1'b1;
      weight_valid = 1'b1;
      bias_valid   = 1'b1;
    end
    oup_valid = (credit_m > 0);
    oup_ready = !bp_hold;
  endtask

  task automatic execute_job(input int j);
    int guard;
    cur_job    = j;
    layer      = jobs[j].layer;
    seq_length = ita_ctrl_pkg::dim_t'(jobs[j].seq);
    proj_space = ita_ctrl_pkg::dim_t'(jobs[j].proj);
    embed_size = ita_ctrl_pkg::dim_t'(jobs[j].embed);
    ff_size    = ita_ctrl_pkg::dim_t'(jobs[j].ff);
    tile_s     = ita_ctrl_pkg::counter_t'(jobs[j].ts);
    tile_p     = ita_ctrl_pkg::counter_t'(jobs[j].tp);
    tile_e     = ita_ctrl_pkg::counter_t'(jobs[j].te);
    tile_f     = ita_ctrl_pkg::counter_t'(jobs[j].tf);
    bp_hold    = jobs[j].bp;
    hold_cnt   = 0;
    saw_full   = 1'b0;
    fires      = '{default: 0};
    start      = 1'b1;
    advance_cycle();
    guard = 0;
    while (step_m != ita_ctrl_pkg::Idle) begin
      advance_cycle();
      guard++;
      if (guard > 4000) stop_on_error($sformatf("timeout: job %0d never returned to Idle", j));
    end
    // 16 beats per 8x8 tile over 4 lanes
    if (jobs[j].layer == ita_ctrl_pkg::Linear) begin
      check_value("calc_en_o beats in MatMul", 128'(fires[int'(ita_ctrl_pkg::MatMul)]),
                  128'(jobs[j].ts * jobs[j].tp * jobs[j].te * 16));
    end else begin
      check_value("calc_en_o beats in F1", 128'(fires[int'(ita_ctrl_pkg::F1)]),
                  128'(jobs[j].ts * jobs[j].tf * jobs[j].te * 16));
      check_value("calc_en_o beats in F2", 128'(fires[int'(ita_ctrl_pkg::F2)]),
                  128'(jobs[j].ts * jobs[j].tf * jobs[j].te * 16));
    end
    if (jobs[j].bp) begin
      assert (saw_full && hold_cnt >= HOLD_CYCLES) else
        stop_on_error("back-pressure never filled the output credits and stalled issue");
    end
    bp_hold = 1'b0;
    guard = 0;
    while (credit_m != 0) begin
      advance_cycle();
      guard++;
      if (guard > 50) stop_on_error("timeout: output credits did not drain");
    end
  endtask

  initial begin
    int guard;
    seed = 32'h1f25_9a68;
    start = 1'b0;
    layer = ita_ctrl_pkg::Linear;
    seq_length = '0;
    proj_space = '0;
    embed_size = '0;
    ff_size = '0;
    tile_s = 8'd1;
    tile_p = 8'd1;
    tile_e = 8'd1;
    tile_f = 8'd1;
    inp_valid = 1'b0;
    weight_valid = 1'b0;
    bias_valid = 1'b0;
    oup_valid = 1'b0;
    oup_ready = 1'b0;
    bias = '0;
    requant_add = 1'b0;
    //         layer                      seq proj embed ff  ts tp te tf  bp    rand_valid
    jobs[0] = '{ita_ctrl_pkg::Linear,      13, 11,  16,  16, 2, 2, 1, 1, 1'b0, 1'b0};
    jobs[1] = '{ita_ctrl_pkg::Feedforward, 5,  8,   9,   12, 1, 1, 2, 2, 1'b0, 1'b1};
    jobs[2] = '{ita_ctrl_pkg::Linear,      16, 21,  8,   8,  2, 3, 2, 1, 1'b1, 1'b0};
    guard = 0;
    while (rst_n !== 1'b1) begin
      @(negedge clk);
      guard++;
      if (guard > 32) stop_on_error("timeout: reset was never released");
    end
    repeat (3) advance_cycle(); // idle checks right after reset
    for (int j = 0; j < NUM_JOBS; j++) execute_job(j);
    if (errors == 0) begin
      $display("All tests passed!");
      $finish;
    end else begin
      $display("Test failures found");
      $fatal(1, "errors were counted during the run");
    end
  end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# build the controller testbench with Verilator, run it, grade the log
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  -f compile.f \
  --top-module tb_ita_controller \
  --Mdir obj_dir

./obj_dir/Vtb_ita_controller 2>&1 | tee sim.log

if grep -q 'All tests passed!' sim.log; then
  echo "simulation PASSED"
else
  echo "simulation FAILED, see sim.log"
  exit 1
fi
